//--- bench/replay_writer_asserts.sv
// ##########################################################################
// Concurrent checks on the replay write engine top level
// Write strobe after reset, stall response, input FIFO pop guard
// ##########################################################################

`default_nettype none

module replay_writer_asserts (
  input logic clk,
  input logic rst,
  input logic mem_wr_n,
  input logic mem_wr_full,
  input logic fifo_pop,
  input logic fifo_empty
);

  timeunit 1ns;
  timeprecision 1ps;

  // Strobe register is cleared by reset
  strobe_idle_after_reset: assert property (@(posedge clk) rst |=> mem_wr_n)
    else $error("write strobe active in the cycle after reset");

  // A full memory blocks the pop, so the port stays quiet next cycle
  no_write_after_full: assert property (
    @(posedge clk) disable iff (rst) mem_wr_full |=> mem_wr_n)
    else $error("memory write issued while the memory was full");

  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (rst) !(fifo_pop && fifo_empty))
    else $error("input FIFO popped while empty");

endmodule

bind replay_writer_top replay_writer_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .mem_wr_n    (mem_wr_n),
  .mem_wr_full (mem_wr_full),
  .fifo_pop    (fifo_pop),
  .fifo_empty  (fifo_empty)
);

`default_nettype wire

//--- bench/replay_writer_tb.sv
// ##########################################################################
// Testbench for the replay write engine
// Clock and reset, packet stimulus with memory stalls, reference model
// of the admitted writes, write checker, tail checks and timeout
// ##########################################################################

`default_nettype none

`include "replay_config.svh"

module replay_writer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROOM_LIMIT  = (1 << `RW_PTR_BITS) - `RW_ROOM_MARGIN;
  localparam int DRAIN_LIMIT = 100;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  replay_pkg::qid_t      in_qid;
  replay_pkg::word_t     in_data;
  logic                  in_full;
  replay_pkg::ptr_vec_t  head_ptr;
  replay_pkg::ptr_vec_t  tail_ptr;
  logic                  mem_wr_full;
  logic                  mem_ready;
  logic                  mem_wr_n;
  replay_pkg::mem_addr_t mem_addr;
  replay_pkg::half_t     mem_dl;
  replay_pkg::half_t     mem_dh;

  integer               seed;
  int                   cycle_cnt;
  int                   cycle_limit;
  int                   word_total;
  int                   ready_low_until;
  logic                 stall_mode;
  logic                 stall_last;
  logic                 full_seen;
  replay_pkg::qid_t     last_qid;
  replay_pkg::ptr_vec_t model_tail;

  // Words still to be pushed in order
  replay_pkg::qid_t  pend_qid [$];
  replay_pkg::word_t pend_data [$];

  // Writes the reference model expects with the oldest first
  replay_pkg::mem_addr_t exp_addr [$];
  replay_pkg::half_t     exp_dl [$];
  replay_pkg::half_t     exp_dh [$];

  replay_writer_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_qid      (in_qid),
    .in_data     (in_data),
    .in_full     (in_full),
    .head_ptr    (head_ptr),
    .tail_ptr    (tail_ptr),
    .mem_wr_full (mem_wr_full),
    .mem_ready   (mem_ready),
    .mem_wr_n    (mem_wr_n),
    .mem_addr    (mem_addr),
    .mem_dl      (mem_dl),
    .mem_dh      (mem_dh)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_addr(input replay_pkg::mem_addr_t got,
                            input replay_pkg::mem_addr_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_half(input replay_pkg::half_t got,
                            input replay_pkg::half_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_ptr(input replay_pkg::ptr_t got,
                           input replay_pkg::ptr_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_strobe(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Reference model with one room check per packet start
  function automatic void model_writes(input replay_pkg::qid_t qids [$],
                                       input replay_pkg::word_t data [$],
                                       input replay_pkg::ptr_vec_t heads,
                                       inout replay_pkg::ptr_vec_t tails);
    logic             admit;
    replay_pkg::ptr_t used;
    replay_pkg::qid_t q;
    admit = 1'b0;
    for (int i = 0; i < qids.size(); i++) begin
      q = qids[i];
      if (i == 0 || q != qids[i-1]) begin
        used  = tails[q] - heads[q];
        admit = int'(used) < ROOM_LIMIT;
      end
      if (admit) begin
        exp_addr.push_back({q, tails[q]});
        exp_dl.push_back(data[i][`RW_DATA_BITS/2-1:0]);
        exp_dh.push_back(data[i][`RW_DATA_BITS-1:`RW_DATA_BITS/2]);
        tails[q] = tails[q] + 1'b1;
      end
    end
  endfunction

  function automatic replay_pkg::word_t random_word();
    logic [159:0] bits;
    bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    return bits[`RW_DATA_BITS-1:0];
  endfunction

  task automatic add_packet(input replay_pkg::qid_t qid, input int len);
    for (int i = 0; i < len; i++) begin
      pend_qid.push_back(qid);
      pend_data.push_back(random_word());
    end
    last_qid    = qid;
    word_total += len;
    cycle_limit = 4 * word_total + 200;
  endtask

  // Next packet always goes to another queue than the last one
  task automatic add_random_packet();
    replay_pkg::qid_t qid;
    int               len;
    qid = last_qid;
    while (qid == last_qid) qid = replay_pkg::qid_t'($random(seed));
    len = 1 + ($random(seed) & 7);
    add_packet(qid, len);
  endtask

  task automatic set_heads(input replay_pkg::ptr_vec_t heads);
    @(posedge clk);
    head_ptr <= heads;
    @(posedge clk);
  endtask

  task automatic push_pending();
    while (pend_qid.size() > 0) begin
      @(posedge clk);
      // At most one push every other cycle since in_full lags a push by one cycle
      if (!in_full && !in_valid) begin
        in_valid <= 1'b1;
        in_qid   <= pend_qid.pop_front();
        in_data  <= pend_data.pop_front();
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic drain();
    int waited;
    stall_mode      = 1'b0;
    ready_low_until = cycle_cnt;
    waited          = 0;
    @(negedge clk);
    while ((exp_addr.size() > 0 || !u_dut.fifo_empty) && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_addr.size() > 0) begin
      $display("Missing writes: %0d expected memory writes never appeared", exp_addr.size());
      abort_run();
    end else if (!u_dut.fifo_empty) begin
      $display("The input FIFO did not drain");
      abort_run();
    end
  endtask

  task automatic check_tails();
    repeat (`RW_TAIL_DELAY + 1) @(negedge clk);
    for (int q = 0; q < `RW_NUM_QUEUES; q++) begin
      check_ptr(tail_ptr[q], model_tail[q], $sformatf("tail_ptr of queue %0d", q));
    end
  endtask

  task automatic run_phase();
    model_writes(pend_qid, pend_data, head_ptr, model_tail);
    push_pending();
    drain();
    check_tails();
  endtask

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        abort_run();
      end
    end
  end

  // Memory side with random write-full stalls and a calibration gap
  initial begin
    mem_wr_full = 1'b0;
    mem_ready   = 1'b0;
    forever begin
      @(posedge clk);
      mem_ready <= (cycle_cnt >= ready_low_until);
      if (stall_mode) mem_wr_full <= 1'($random(seed) & 1);
      else mem_wr_full <= 1'b0;
    end
  end

  // Write checker for writes that show one cycle after their pop
  initial begin
    stall_last = 1'b1;
    full_seen  = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (in_full) full_seen = 1'b1;
        if (!mem_wr_n) begin
          if (stall_last) begin
            $display("A memory write appeared after a cycle with the memory stalled");
            abort_run();
          end else if (exp_addr.size() == 0) begin
            $display("A memory write appeared that the reference model does not expect");
            abort_run();
          end else begin
            check_addr(mem_addr, exp_addr.pop_front(), "mem_addr");
            check_half(mem_dl, exp_dl.pop_front(), "mem_dl");
            check_half(mem_dh, exp_dh.pop_front(), "mem_dh");
          end
        end
        stall_last = mem_wr_full || !mem_ready;
      end
    end
  end

  initial begin
    replay_pkg::ptr_vec_t heads;
    seed            = 32'h4233;
    rst             = 1'b1;
    in_valid        = 1'b0;
    in_qid          = '0;
    in_data         = '0;
    head_ptr        = '0;
    stall_mode      = 1'b0;
    ready_low_until = 0;
    word_total      = 0;
    cycle_limit     = 200;
    last_qid        = '0;
    model_tail      = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_strobe(mem_wr_n, 1'b1, "mem_wr_n after reset");
    check_tails();

    // Plain traffic with room in every queue
    repeat (12) add_random_packet();
    run_phase();

    // Random write-full and a stretch without calibration
    repeat (14) add_random_packet();
    stall_mode      = 1'b1;
    ready_low_until = cycle_cnt + 40;
    run_phase();
    if (!full_seen) begin
      $display("The input FIFO never reported full during the stall");
      abort_run();
    end

    // Reader 10 words ahead makes queue 2 look almost full
    heads    = model_tail;
    heads[2] = model_tail[2] + 8'd10;
    set_heads(heads);
    if (last_qid == 2'd2) add_random_packet();
    add_packet(2'd2, 6);
    add_packet(2'd1, 5);
    add_packet(2'd2, 3);
    add_packet(2'd0, 4);
    run_phase();

    // More than 256 words into queue 3 with the reader keeping up
    for (int r = 0; r < 9; r++) begin
      set_heads(model_tail);
      if (last_qid == 2'd3) add_random_packet();
      for (int k = 0; k < 4; k++) begin
        add_packet(2'd3, 8);
        add_packet(replay_pkg::qid_t'(k % 3), 1 + ($random(seed) & 7));
      end
      run_phase();
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/mem_write_ctrl.sv
// ##########################################################################
// Packet admission controller
// IDLE/WRITE/DROP state machine, one room check per packet,
// pops the input FIFO and issues memory writes
// ##########################################################################

`default_nettype none

module mem_write_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               fifo_empty,
  input  replay_pkg::qid_t   fifo_qid,
  input  replay_pkg::word_t  fifo_data,
  output logic               fifo_pop,
  input  logic               has_room,
  output logic               ptr_adv,
  output replay_pkg::qid_t   cur_qid,
  input  logic               mem_wr_full,
  input  logic               mem_ready,
  output logic               wr_en,
  output replay_pkg::word_t  wr_data
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    DROP
  } state_t;

  state_t           state;
  state_t           state_next;
  replay_pkg::qid_t pkt_qid;
  replay_pkg::qid_t pkt_qid_next;
  logic             same_pkt;
  logic             mem_ok;

  // In IDLE the room check looks at the waiting packet
  assign cur_qid  = (state == IDLE) ? fifo_qid : pkt_qid;
  assign same_pkt = (fifo_qid == pkt_qid);
  assign mem_ok   = !mem_wr_full && mem_ready;
  assign wr_data  = fifo_data;

  always_comb begin
    state_next   = state;
    pkt_qid_next = pkt_qid;
    fifo_pop     = 1'b0;
    wr_en        = 1'b0;
    ptr_adv      = 1'b0;
    unique case (state)
      IDLE: begin
        if (!fifo_empty) begin
          pkt_qid_next = fifo_qid;
          state_next   = has_room ? WRITE : DROP;
        end
      end
      WRITE: begin
        if (!fifo_empty) begin
          if (!same_pkt) begin
            state_next = IDLE;
          end else if (mem_ok) begin
            fifo_pop = 1'b1;
            wr_en    = 1'b1;
            ptr_adv  = 1'b1;
          end
        end
      end
      DROP: begin
        // Discard at full rate, memory state does not matter
        if (!fifo_empty) begin
          if (!same_pkt) state_next = IDLE;
          else fifo_pop = 1'b1;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      pkt_qid <= '0;
    end else begin
      state   <= state_next;
      pkt_qid <= pkt_qid_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mem_write_port.sv
// ##########################################################################
// Registered memory write port
// Active-low write strobe, region address from queue id
// and pointer, word split into low and high halves
// ##########################################################################

`default_nettype none

module mem_write_port (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  replay_pkg::qid_t       wr_qid,
  input  replay_pkg::ptr_t       wr_ptr,
  input  replay_pkg::word_t      wr_data,
  output logic                   mem_wr_n,
  output replay_pkg::mem_addr_t  mem_addr,
  output replay_pkg::half_t      mem_dl,
  output replay_pkg::half_t      mem_dh
);

  localparam int HALF = $bits(replay_pkg::half_t);

  // One strobe cycle per accepted word
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_n <= 1'b1;
    end else begin
      mem_wr_n <= !wr_en;
    end
  end

  // Address and data only change with a write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_addr <= {wr_qid, wr_ptr};
      mem_dl   <= wr_data[HALF-1:0];
      mem_dh   <= wr_data[2*HALF-1:HALF];
    end
  end

endmodule

`default_nettype wire

//--- hdl/queue_ptr_bank.sv
// ##########################################################################
// Per-queue tail pointer bank
// Live tails with single step advance, room check against
// the reader's head pointers, delayed tail publication
// ##########################################################################

`default_nettype none

`include "replay_config.svh"

module queue_ptr_bank (
  input  logic                  clk,
  input  logic                  rst,
  input  replay_pkg::qid_t      room_qid,
  output logic                  has_room,
  input  logic                  adv,
  input  replay_pkg::qid_t      adv_qid,
  output replay_pkg::ptr_t      cur_ptr,
  input  replay_pkg::ptr_vec_t  head_ptr,
  output replay_pkg::ptr_vec_t  tail_ptr
);

  // Occupancy must stay below region size minus margin
  localparam int unsigned ROOM_LIMIT = (1 << `RW_PTR_BITS) - `RW_ROOM_MARGIN;

  replay_pkg::ptr_vec_t live_tail;
  replay_pkg::ptr_vec_t tail_line [`RW_TAIL_DELAY];
  replay_pkg::ptr_t     used;

  // Modulo difference handles a wrapped tail
  assign used     = live_tail[room_qid] - head_ptr[room_qid];
  assign has_room = 32'(used) < ROOM_LIMIT;

  // Value before the advance, this is the word being written
  assign cur_ptr = live_tail[adv_qid];

  assign tail_ptr = tail_line[`RW_TAIL_DELAY-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      live_tail <= '0;
    end else if (adv) begin
      live_tail[adv_qid] <= live_tail[adv_qid] + 1'b1;
    end
  end

  // Publication lags the live tail to cover the memory write latency
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RW_TAIL_DELAY; i++) begin
        tail_line[i] <= '0;
      end
    end else begin
      tail_line[0] <= live_tail;
      for (int i = 1; i < `RW_TAIL_DELAY; i++) begin
        tail_line[i] <= tail_line[i-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/replay_config.svh
// ##########################################################################
// Size settings for the replay write engine
// Queue count and id width, word and pointer widths,
// admission margin, input FIFO depth and tail publish delay
// ##########################################################################

`ifndef REPLAY_CONFIG_SVH
`define REPLAY_CONFIG_SVH

// Queues and their id width
`define RW_NUM_QUEUES 4
`define RW_QID_BITS 2

// Capture word width, written to memory as two halves
`define RW_DATA_BITS 144

// Per-queue word pointer, 256 words per region
`define RW_PTR_BITS 8

// Words that must stay free for a packet to be admitted
`define RW_ROOM_MARGIN 16

`define RW_FIFO_DEPTH 16
`define RW_TAIL_DELAY 4

`endif

//--- hdl/replay_pkg.sv
// ##########################################################################
// Shared types of the replay write engine
// Queue id, capture word, memory half word, pointer,
// memory address and per-queue pointer vector
// ##########################################################################

`default_nettype none

`include "replay_config.svh"

package replay_pkg;

  typedef logic [`RW_QID_BITS-1:0] qid_t;

  typedef logic [`RW_DATA_BITS-1:0] word_t;

  // One memory beat carries half of a capture word
  typedef logic [`RW_DATA_BITS/2-1:0] half_t;

  typedef logic [`RW_PTR_BITS-1:0] ptr_t;

  // Queue id selects the region, pointer selects the word inside it
  typedef logic [`RW_QID_BITS+`RW_PTR_BITS-1:0] mem_addr_t;

  // Head and tail pointers of all queues
  typedef ptr_t [`RW_NUM_QUEUES-1:0] ptr_vec_t;

endpackage

`default_nettype wire

//--- hdl/replay_writer_top.sv
// ##########################################################################
// Replay write engine top level
// Input FIFO, admission controller, tail pointer bank
// and memory write port
// ##########################################################################

`default_nettype none

module replay_writer_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  replay_pkg::qid_t       in_qid,
  input  replay_pkg::word_t      in_data,
  output logic                   in_full,
  input  replay_pkg::ptr_vec_t   head_ptr,
  output replay_pkg::ptr_vec_t   tail_ptr,
  input  logic                   mem_wr_full,
  input  logic                   mem_ready,
  output logic                   mem_wr_n,
  output replay_pkg::mem_addr_t  mem_addr,
  output replay_pkg::half_t      mem_dl,
  output replay_pkg::half_t      mem_dh
);

  replay_pkg::qid_t  fifo_qid;
  replay_pkg::word_t fifo_data;
  logic              fifo_empty;
  logic              fifo_pop;
  logic              has_room;
  logic              ptr_adv;
  replay_pkg::qid_t  cur_qid;
  replay_pkg::ptr_t  cur_ptr;
  logic              wr_en;
  replay_pkg::word_t wr_data;

  word_fifo u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (in_valid),
    .push_qid  (in_qid),
    .push_data (in_data),
    .full      (in_full),
    .pop       (fifo_pop),
    .head_qid  (fifo_qid),
    .head_data (fifo_data),
    .empty     (fifo_empty)
  );

  mem_write_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .fifo_empty  (fifo_empty),
    .fifo_qid    (fifo_qid),
    .fifo_data   (fifo_data),
    .fifo_pop    (fifo_pop),
    .has_room    (has_room),
    .ptr_adv     (ptr_adv),
    .cur_qid     (cur_qid),
    .mem_wr_full (mem_wr_full),
    .mem_ready   (mem_ready),
    .wr_en       (wr_en),
    .wr_data     (wr_data)
  );

  // Same queue id drives the room check and the advance
  queue_ptr_bank u_ptrs (
    .clk      (clk),
    .rst      (rst),
    .room_qid (cur_qid),
    .has_room (has_room),
    .adv      (ptr_adv),
    .adv_qid  (cur_qid),
    .cur_ptr  (cur_ptr),
    .head_ptr (head_ptr),
    .tail_ptr (tail_ptr)
  );

  mem_write_port u_port (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_qid   (cur_qid),
    .wr_ptr   (cur_ptr),
    .wr_data  (wr_data),
    .mem_wr_n (mem_wr_n),
    .mem_addr (mem_addr),
    .mem_dl   (mem_dl),
    .mem_dh   (mem_dh)
  );

endmodule

`default_nettype wire

//--- hdl/word_fifo.sv
// ##########################################################################
// Input FIFO of the replay write engine
// Holds a capture word and its queue id per entry,
// head entry is shown unregistered for the controller
// ##########################################################################

`default_nettype none

`include "replay_config.svh"

module word_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  replay_pkg::qid_t    push_qid,
  input  replay_pkg::word_t   push_data,
  output logic                full,
  input  logic                pop,
  output replay_pkg::qid_t    head_qid,
  output replay_pkg::word_t   head_data,
  output logic                empty
);

  localparam int AW = $clog2(`RW_FIFO_DEPTH);

  replay_pkg::qid_t  qid_mem  [`RW_FIFO_DEPTH];
  replay_pkg::word_t data_mem [`RW_FIFO_DEPTH];

  logic [AW-1:0] rd_idx;
  logic [AW-1:0] wr_idx;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  // Strobes at the wrong moment are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == (AW+1)'(`RW_FIFO_DEPTH));
  assign empty = (count == '0);

  assign head_qid  = qid_mem[rd_idx];
  assign head_data = data_mem[rd_idx];

  always_ff @(posedge clk) begin
    if (do_push) begin
      qid_mem[wr_idx]  <= push_qid;
      data_mem[wr_idx] <= push_data;
    end
  end

  // Depth is a power of two so the indexes wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_idx <= '0;
      wr_idx <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_idx <= wr_idx + 1'b1;
      if (do_pop) rd_idx <= rd_idx + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/replay_pkg.sv
hdl/word_fifo.sv
hdl/queue_ptr_bank.sv
hdl/mem_write_ctrl.sv
hdl/mem_write_port.sv
hdl/replay_writer_top.sv
bench/replay_writer_asserts.sv
bench/replay_writer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the replay writer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module replay_writer_tb -Mdir obj_dir

output=$(./obj_dir/Vreplay_writer_tb 2>&1) || true
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
